// File: Makefile
SIM := obj_dir/Vissue_tb

.PHONY: all run clean

all: run

$(SIM): compile.f $(wildcard hdl/*.sv tb/*.sv)
	verilator --binary --assert --top-module issue_tb -f compile.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
hdl/issue_pkg.sv
hdl/issue_scoreboard.sv
hdl/long_exec_unit.sv
hdl/issue_top.sv
tb/issue_assertions.sv
tb/issue_tb.sv

// File: hdl/issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int REG_ADDR_W = 5;   // x0..x31
    localparam int ID_W       = 3;   // commit id, 0 means none
    localparam int NUM_IDS    = 8;   // slot 0 reserved, 7 usable

    // operation classes
    localparam int OP_W = 2;
    localparam logic [OP_W-1:0] OP_ALU = 2'd0;
    localparam logic [OP_W-1:0] OP_MUL = 2'd1;
    localparam logic [OP_W-1:0] OP_DIV = 2'd2;

    // execution latency per class, in cycles
    localparam int LAT_ALU = 1;
    localparam int LAT_MUL = 3;
    localparam int LAT_DIV = 6;

    // countdown width, holds LAT_DIV-1
    localparam int LAT_W = $clog2(LAT_DIV);

endpackage

`default_nettype wire

// File: hdl/issue_scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

module issue_scoreboard (
    input  logic                             clk,
    input  logic                             rst_n,
    // slot A, older in program order
    input  logic                             inst1_valid_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst1_rs1_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst1_rs2_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst1_rd_i,
    input  logic                             inst1_rd_we_i,
    input  logic                             inst1_branch_i,
    input  logic                             inst1_jump_i,
    // slot B
    input  logic                             inst2_valid_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst2_rs1_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst2_rs2_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst2_rd_i,
    input  logic                             inst2_rd_we_i,
    input  logic                             irq_i,           // stalls both slots
    // retirements from the execution model
    input  logic                             commit0_valid_i,
    input  logic [issue_pkg::ID_W-1:0]       commit0_id_i,
    input  logic                             commit1_valid_i,
    input  logic [issue_pkg::ID_W-1:0]       commit1_id_i,
    output logic [1:0]                       issue_o,         // bit0 A, bit1 B
    output logic [issue_pkg::ID_W-1:0]       inst1_id_o,
    output logic [issue_pkg::ID_W-1:0]       inst2_id_o,
    output logic                             alloc1_o,
    output logic                             alloc2_o,
    output logic                             busy_o
);

    logic [issue_pkg::NUM_IDS-1:0]    ent_valid;                    // pending writes
    logic [issue_pkg::REG_ADDR_W-1:0] ent_rd [issue_pkg::NUM_IDS];
    logic [issue_pkg::NUM_IDS-1:0]    ent_live;                     // valid, not retiring now
    logic [issue_pkg::ID_W:0]         used_cnt;
    logic                             room_two;
    logic a_rs1_chk, a_rs2_chk, a_rd_chk;
    logic b_rs1_chk, b_rs2_chk, b_rd_chk;
    logic haz_a_tab, haz_b_tab, haz_b_a;
    logic a_serial;                                                 // branch/jump in A
    logic [1:0]                       issue_mask;
    logic [issue_pkg::ID_W-1:0]       id1, id2;

    // x0 never creates a dependence
    assign a_rs1_chk = inst1_valid_i && (inst1_rs1_i != '0);
    assign a_rs2_chk = inst1_valid_i && (inst1_rs2_i != '0);
    assign a_rd_chk  = inst1_valid_i && inst1_rd_we_i && (inst1_rd_i != '0);
    assign b_rs1_chk = inst2_valid_i && (inst2_rs1_i != '0);
    assign b_rs2_chk = inst2_valid_i && (inst2_rs2_i != '0);
    assign b_rd_chk  = inst2_valid_i && inst2_rd_we_i && (inst2_rd_i != '0);
    assign a_serial  = inst1_valid_i && (inst1_branch_i || inst1_jump_i);

    // drop entries whose commit strobe is up this cycle
    always_comb begin
        for (int i = 0; i < issue_pkg::NUM_IDS; i++) begin
            ent_live[i] = ent_valid[i]
                && !(commit0_valid_i && commit0_id_i == (issue_pkg::ID_W)'(i))
                && !(commit1_valid_i && commit1_id_i == (issue_pkg::ID_W)'(i));
        end
    end

    // RAW and WAW against the table
    always_comb begin
        haz_a_tab = 1'b0;
        haz_b_tab = 1'b0;
        for (int i = 1; i < issue_pkg::NUM_IDS; i++) begin
            if (ent_live[i]) begin
                if ((a_rs1_chk && inst1_rs1_i == ent_rd[i]) ||
                    (a_rs2_chk && inst1_rs2_i == ent_rd[i]) ||
                    (a_rd_chk  && inst1_rd_i  == ent_rd[i])) begin
                    haz_a_tab = 1'b1;
                end
                if ((b_rs1_chk && inst2_rs1_i == ent_rd[i]) ||
                    (b_rs2_chk && inst2_rs2_i == ent_rd[i]) ||
                    (b_rd_chk  && inst2_rd_i  == ent_rd[i])) begin
                    haz_b_tab = 1'b1;
                end
            end
        end
    end

    // B reads or overwrites what A writes
    assign haz_b_a = a_rd_chk && ((b_rs1_chk && inst2_rs1_i == inst1_rd_i) ||
                                  (b_rs2_chk && inst2_rs2_i == inst1_rd_i) ||
                                  (b_rd_chk  && inst2_rd_i  == inst1_rd_i));

    // occupancy over slots 1..7
    always_comb begin
        used_cnt = '0;
        for (int i = 1; i < issue_pkg::NUM_IDS; i++) begin
            used_cnt = used_cnt + {{issue_pkg::ID_W{1'b0}}, ent_valid[i]};
        end
    end
    assign room_two = used_cnt <= (issue_pkg::ID_W + 1)'(issue_pkg::NUM_IDS - 3);

    always_comb begin
        issue_mask = 2'b00;
        if (!room_two || irq_i) begin
            issue_mask = 2'b00;                                     // full or interrupt
        end else if (haz_a_tab) begin
            if (!a_serial && !haz_b_tab && !haz_b_a) begin
                issue_mask = 2'b10;                                 // B slips past A
            end
        end else if (a_serial || haz_b_tab || haz_b_a) begin
            issue_mask = 2'b01;
        end else begin
            issue_mask = 2'b11;
        end
    end
    assign issue_o = issue_mask & {inst2_valid_i, inst1_valid_i};

    // id1 lowest free, id2 next free after id1 with wrap in 1..7
    always_comb begin
        int idx;
        id1 = '0;
        id2 = '0;
        for (int i = issue_pkg::NUM_IDS - 1; i >= 1; i--) begin
            if (!ent_valid[i]) begin
                id1 = (issue_pkg::ID_W)'(i);                        // downward scan, lowest wins
            end
        end
        for (int k = issue_pkg::NUM_IDS - 2; k >= 1; k--) begin
            idx = (int'(id1) - 1 + k) % (issue_pkg::NUM_IDS - 1) + 1;
            if (!ent_valid[idx]) begin
                id2 = (issue_pkg::ID_W)'(idx);
            end
        end
    end

    assign inst1_id_o = issue_o[0] ? id1 : '0;
    assign inst2_id_o = issue_o[1] ? id2 : '0;
    assign alloc1_o   = issue_o[0] && a_rd_chk;                     // only real writers enter
    assign alloc2_o   = issue_o[1] && b_rd_chk;
    assign busy_o     = |ent_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
        end else begin
            if (commit0_valid_i) begin
                ent_valid[commit0_id_i] <= 1'b0;
            end
            if (commit1_valid_i) begin
                ent_valid[commit1_id_i] <= 1'b0;
            end
            // allocs only hit free slots, never a retiring one
            if (alloc1_o) begin
                ent_valid[inst1_id_o] <= 1'b1;
            end
            if (alloc2_o) begin
                ent_valid[inst2_id_o] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc1_o) begin
            ent_rd[inst1_id_o] <= inst1_rd_i;
        end
        if (alloc2_o) begin
            ent_rd[inst2_id_o] <= inst2_rd_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/issue_top.sv
`timescale 1ns/100ps
`default_nettype none

module issue_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             inst1_valid_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst1_rs1_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst1_rs2_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst1_rd_i,
    input  logic                             inst1_rd_we_i,
    input  logic [issue_pkg::OP_W-1:0]       inst1_op_i,
    input  logic                             inst1_branch_i,
    input  logic                             inst1_jump_i,
    input  logic                             inst2_valid_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst2_rs1_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst2_rs2_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] inst2_rd_i,
    input  logic                             inst2_rd_we_i,
    input  logic [issue_pkg::OP_W-1:0]       inst2_op_i,
    input  logic                             irq_i,
    output logic [1:0]                       issue_o,
    output logic [issue_pkg::ID_W-1:0]       inst1_id_o,
    output logic [issue_pkg::ID_W-1:0]       inst2_id_o,
    output logic                             busy_o,
    output logic                             wb0_valid_o,
    output logic [issue_pkg::ID_W-1:0]       wb0_id_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] wb0_rd_o,
    output logic                             wb1_valid_o,
    output logic [issue_pkg::ID_W-1:0]       wb1_id_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] wb1_rd_o
);

    logic alloc1, alloc2;                           // scoreboard -> exec
    logic commit0_valid, commit1_valid;             // exec -> scoreboard and wb
    logic [issue_pkg::ID_W-1:0] commit0_id, commit1_id;

    issue_scoreboard i_issue_scoreboard (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst1_valid_i   (inst1_valid_i),
        .inst1_rs1_i     (inst1_rs1_i),
        .inst1_rs2_i     (inst1_rs2_i),
        .inst1_rd_i      (inst1_rd_i),
        .inst1_rd_we_i   (inst1_rd_we_i),
        .inst1_branch_i  (inst1_branch_i),
        .inst1_jump_i    (inst1_jump_i),
        .inst2_valid_i   (inst2_valid_i),
        .inst2_rs1_i     (inst2_rs1_i),
        .inst2_rs2_i     (inst2_rs2_i),
        .inst2_rd_i      (inst2_rd_i),
        .inst2_rd_we_i   (inst2_rd_we_i),
        .irq_i           (irq_i),
        .commit0_valid_i (commit0_valid),
        .commit0_id_i    (commit0_id),
        .commit1_valid_i (commit1_valid),
        .commit1_id_i    (commit1_id),
        .issue_o         (issue_o),
        .inst1_id_o      (inst1_id_o),
        .inst2_id_o      (inst2_id_o),
        .alloc1_o        (alloc1),
        .alloc2_o        (alloc2),
        .busy_o          (busy_o)
    );

    // rd and op taken straight from the issue inputs
    long_exec_unit i_long_exec_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc1_i        (alloc1),
        .alloc1_id_i     (inst1_id_o),
        .alloc1_rd_i     (inst1_rd_i),
        .alloc1_op_i     (inst1_op_i),
        .alloc2_i        (alloc2),
        .alloc2_id_i     (inst2_id_o),
        .alloc2_rd_i     (inst2_rd_i),
        .alloc2_op_i     (inst2_op_i),
        .commit0_valid_o (commit0_valid),
        .commit0_id_o    (commit0_id),
        .commit0_rd_o    (wb0_rd_o),
        .commit1_valid_o (commit1_valid),
        .commit1_id_o    (commit1_id),
        .commit1_rd_o    (wb1_rd_o)
    );

    // commits are the writeback ports
    assign wb0_valid_o = commit0_valid;
    assign wb0_id_o    = commit0_id;
    assign wb1_valid_o = commit1_valid;
    assign wb1_id_o    = commit1_id;

endmodule

`default_nettype wire

// File: hdl/long_exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module long_exec_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             alloc1_i,
    input  logic [issue_pkg::ID_W-1:0]       alloc1_id_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] alloc1_rd_i,
    input  logic [issue_pkg::OP_W-1:0]       alloc1_op_i,
    input  logic                             alloc2_i,
    input  logic [issue_pkg::ID_W-1:0]       alloc2_id_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] alloc2_rd_i,
    input  logic [issue_pkg::OP_W-1:0]       alloc2_op_i,
    output logic                             commit0_valid_o,   // lowest ready id
    output logic [issue_pkg::ID_W-1:0]       commit0_id_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] commit0_rd_o,
    output logic                             commit1_valid_o,   // second lowest
    output logic [issue_pkg::ID_W-1:0]       commit1_id_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] commit1_rd_o
);

    logic [issue_pkg::NUM_IDS-1:0]    slot_busy;
    logic [issue_pkg::LAT_W-1:0]      slot_cnt [issue_pkg::NUM_IDS];    // cycles left
    logic [issue_pkg::REG_ADDR_W-1:0] slot_rd  [issue_pkg::NUM_IDS];
    logic [issue_pkg::NUM_IDS-1:0]    ready;
    logic                             pick0_ok, pick1_ok;
    logic [issue_pkg::ID_W-1:0]       pick0, pick1;

    // count loaded at alloc, zero means eligible next cycle
    function automatic logic [issue_pkg::LAT_W-1:0] first_count(
        input logic [issue_pkg::OP_W-1:0] op
    );
        case (op)
            issue_pkg::OP_ALU: first_count = (issue_pkg::LAT_W)'(issue_pkg::LAT_ALU - 1);
            issue_pkg::OP_MUL: first_count = (issue_pkg::LAT_W)'(issue_pkg::LAT_MUL - 1);
            issue_pkg::OP_DIV: first_count = (issue_pkg::LAT_W)'(issue_pkg::LAT_DIV - 1);
            default:           first_count = (issue_pkg::LAT_W)'(issue_pkg::LAT_ALU - 1);
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < issue_pkg::NUM_IDS; i++) begin
            ready[i] = slot_busy[i] && (slot_cnt[i] == '0);
        end
    end

    // two lowest ready ids, the rest wait a round
    always_comb begin
        pick0_ok = 1'b0;
        pick1_ok = 1'b0;
        pick0    = '0;
        pick1    = '0;
        for (int i = 1; i < issue_pkg::NUM_IDS; i++) begin
            if (ready[i] && !pick0_ok) begin
                pick0_ok = 1'b1;
                pick0    = (issue_pkg::ID_W)'(i);
            end else if (ready[i] && !pick1_ok) begin
                pick1_ok = 1'b1;
                pick1    = (issue_pkg::ID_W)'(i);
            end
        end
    end

    // straight from state, no output flops
    assign commit0_valid_o = pick0_ok;
    assign commit0_id_o    = pick0;
    assign commit0_rd_o    = pick0_ok ? slot_rd[pick0] : '0;
    assign commit1_valid_o = pick1_ok;
    assign commit1_id_o    = pick1;
    assign commit1_rd_o    = pick1_ok ? slot_rd[pick1] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_busy <= '0;
            for (int i = 0; i < issue_pkg::NUM_IDS; i++) begin
                slot_cnt[i] <= '0;
            end
        end else begin
            for (int i = 1; i < issue_pkg::NUM_IDS; i++) begin
                if (slot_busy[i] && slot_cnt[i] != '0) begin
                    slot_cnt[i] <= slot_cnt[i] - 1'b1;
                end
            end
            if (pick0_ok) begin
                slot_busy[pick0] <= 1'b0;
            end
            if (pick1_ok) begin
                slot_busy[pick1] <= 1'b0;
            end
            if (alloc1_i) begin
                slot_busy[alloc1_id_i] <= 1'b1;
                slot_cnt[alloc1_id_i]  <= first_count(alloc1_op_i);
            end
            if (alloc2_i) begin
                slot_busy[alloc2_id_i] <= 1'b1;
                slot_cnt[alloc2_id_i]  <= first_count(alloc2_op_i);
            end
        end
    end

    // destination kept until retirement
    always_ff @(posedge clk) begin
        if (alloc1_i) begin
            slot_rd[alloc1_id_i] <= alloc1_rd_i;
        end
        if (alloc2_i) begin
            slot_rd[alloc2_id_i] <= alloc2_rd_i;
        end
    end

endmodule

`default_nettype wire

// File: tb/issue_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module issue_assertions (
    input logic                       clk,
    input logic                       rst_n,
    input logic [1:0]                 issue_i,
    input logic [issue_pkg::ID_W-1:0] inst1_id_i,
    input logic [issue_pkg::ID_W-1:0] inst2_id_i,
    input logic                       wb0_valid_i,
    input logic [issue_pkg::ID_W-1:0] wb0_id_i,
    input logic                       wb1_valid_i,
    input logic [issue_pkg::ID_W-1:0] wb1_id_i
);

    wb_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !wb0_valid_i && !wb1_valid_i)
        else $error("writeback valid while in reset");

    // id 0 is reserved
    wb0_id_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb0_valid_i |-> wb0_id_i != '0) else $error("wb0 carries id 0");
    wb1_id_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb1_valid_i |-> wb1_id_i != '0) else $error("wb1 carries id 0");

    wb_ids_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        wb0_valid_i && wb1_valid_i |-> wb0_id_i != wb1_id_i)
        else $error("both writeback ports carry the same id");

    issue_ids_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (!issue_i[0] || inst1_id_i != '0) && (!issue_i[1] || inst2_id_i != '0) &&
        (issue_i != 2'b11 || inst1_id_i != inst2_id_i))
        else $error("issued ids zero or equal");

endmodule

bind issue_top issue_assertions i_issue_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_i     (issue_o),
    .inst1_id_i  (inst1_id_o),
    .inst2_id_i  (inst2_id_o),
    .wb0_valid_i (wb0_valid_o),
    .wb0_id_i    (wb0_id_o),
    .wb1_valid_i (wb1_valid_o),
    .wb1_id_i    (wb1_id_o)
);

`default_nettype wire

// File: tb/issue_tb.sv
`timescale 1ns/100ps
`default_nettype none

module issue_tb;

    localparam int HOLD_LIMIT   = 40;     // cycles a pair may stall
    localparam int RAND_CYCLES  = 2000;

    logic                             clk;
    logic                             rst_n;
    logic                             inst1_valid_i, inst1_rd_we_i, inst1_branch_i, inst1_jump_i;
    logic [issue_pkg::REG_ADDR_W-1:0] inst1_rs1_i, inst1_rs2_i, inst1_rd_i;
    logic [issue_pkg::OP_W-1:0]       inst1_op_i;
    logic                             inst2_valid_i, inst2_rd_we_i;
    logic [issue_pkg::REG_ADDR_W-1:0] inst2_rs1_i, inst2_rs2_i, inst2_rd_i;
    logic [issue_pkg::OP_W-1:0]       inst2_op_i;
    logic                             irq_i;
    logic [1:0]                       issue_o;
    logic [issue_pkg::ID_W-1:0]       inst1_id_o, inst2_id_o, wb0_id_o, wb1_id_o;
    logic                             busy_o, wb0_valid_o, wb1_valid_o;
    logic [issue_pkg::REG_ADDR_W-1:0] wb0_rd_o, wb1_rd_o;

    // reference model of the pending-write table
    logic                             m_pend [issue_pkg::NUM_IDS];
    logic [issue_pkg::REG_ADDR_W-1:0] m_rd   [issue_pkg::NUM_IDS];
    int                               m_rem  [issue_pkg::NUM_IDS];   // cycles to eligibility
    logic [1:0]                       last_issue;                    // mask seen at last edge
    logic [31:0]                      rng_state;
    int n_cycle, n_issue, n_dual, n_alloc, n_retire;

    issue_top i_issue_top (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int op_latency(input logic [issue_pkg::OP_W-1:0] op);
        case (op)
            issue_pkg::OP_MUL: return issue_pkg::LAT_MUL;
            issue_pkg::OP_DIV: return issue_pkg::LAT_DIV;
            default:           return issue_pkg::LAT_ALU;   // alu and unused code 3
        endcase
    endfunction

    // RAW/WAW against live entries other than the retiring c0/c1
    function automatic logic table_conflict(
        input logic [issue_pkg::REG_ADDR_W-1:0] rs1,
        input logic [issue_pkg::REG_ADDR_W-1:0] rs2,
        input logic [issue_pkg::REG_ADDR_W-1:0] rd,
        input logic                             we,
        input logic [issue_pkg::ID_W-1:0]       c0,
        input logic [issue_pkg::ID_W-1:0]       c1
    );
        logic hit;
        hit = 1'b0;
        for (int i = 1; i < issue_pkg::NUM_IDS; i++) begin
            if (m_pend[i] && i != int'(c0) && i != int'(c1)) begin
                if ((rs1 != '0 && rs1 == m_rd[i]) || (rs2 != '0 && rs2 == m_rd[i]) ||
                    (we && rd != '0 && rd == m_rd[i])) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // expected issue mask from the decision rules
    function automatic logic [1:0] ref_issue(
        input logic [issue_pkg::ID_W-1:0] c0,
        input logic [issue_pkg::ID_W-1:0] c1
    );
        logic a_tab, b_tab, b_on_a, a_ser, a_wr;
        logic [1:0] mask;
        int free_cnt;
        free_cnt = 0;
        for (int i = 1; i < issue_pkg::NUM_IDS; i++) begin
            if (!m_pend[i]) free_cnt++;
        end
        a_tab = inst1_valid_i && table_conflict(inst1_rs1_i, inst1_rs2_i, inst1_rd_i,
                                                inst1_rd_we_i, c0, c1);
        b_tab = inst2_valid_i && table_conflict(inst2_rs1_i, inst2_rs2_i, inst2_rd_i,
                                                inst2_rd_we_i, c0, c1);
        a_wr   = inst1_valid_i && inst1_rd_we_i && inst1_rd_i != '0;
        b_on_a = a_wr && inst2_valid_i && (inst2_rs1_i == inst1_rd_i ||
                 inst2_rs2_i == inst1_rd_i || (inst2_rd_we_i && inst2_rd_i == inst1_rd_i));
        a_ser  = inst1_valid_i && (inst1_branch_i || inst1_jump_i);
        if (free_cnt < 2 || irq_i) begin
            mask = 2'b00;
        end else if (a_tab) begin
            mask = (!a_ser && !b_tab && !b_on_a) ? 2'b10 : 2'b00;   // B may slip past
        end else if (a_ser || b_tab || b_on_a) begin
            mask = 2'b01;
        end else begin
            mask = 2'b11;
        end
        return mask & {inst2_valid_i, inst1_valid_i};
    endfunction

    function automatic logic [issue_pkg::ID_W-1:0] lowest_free();
        for (int i = 1; i < issue_pkg::NUM_IDS; i++) begin
            if (!m_pend[i]) return (issue_pkg::ID_W)'(i);
        end
        return '0;
    endfunction

    // next free after id1 with a step from 7 back to 1
    function automatic logic [issue_pkg::ID_W-1:0] next_free(
        input logic [issue_pkg::ID_W-1:0] id1
    );
        int idx;
        idx = int'(id1);
        for (int k = 1; k < issue_pkg::NUM_IDS - 1; k++) begin
            idx = (idx >= issue_pkg::NUM_IDS - 1) ? 1 : idx + 1;
            if (!m_pend[idx]) return (issue_pkg::ID_W)'(idx);
        end
        return '0;
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // compare outputs with the model and then advance it
    always @(posedge clk) begin : compare_outputs
        logic [issue_pkg::ID_W-1:0] c0, c1, f1, f2;
        logic [1:0] e_mask;
        logic any_pend;
        c0 = '0;
        c1 = '0;
        any_pend = 1'b0;
        if (!rst_n) begin
            check_value("issue_o in reset", int'(issue_o), 0);
            check_value("busy_o in reset", int'(busy_o), 0);
            check_value("wb valids in reset", int'({wb1_valid_o, wb0_valid_o}), 0);
            last_issue = 2'b00;
        end else begin
            n_cycle++;
            for (int i = 1; i < issue_pkg::NUM_IDS; i++) begin
                any_pend = any_pend | m_pend[i];
                if (m_pend[i] && m_rem[i] == 0) begin      // two lowest eligible retire
                    if (c0 == '0) c0 = (issue_pkg::ID_W)'(i);
                    else if (c1 == '0) c1 = (issue_pkg::ID_W)'(i);
                end
            end
            check_value("wb0_valid_o", int'(wb0_valid_o), int'(c0 != '0));
            check_value("wb0_id_o", int'(wb0_id_o), int'(c0));
            check_value("wb0_rd_o", int'(wb0_rd_o), (c0 != '0) ? int'(m_rd[c0]) : 0);
            check_value("wb1_valid_o", int'(wb1_valid_o), int'(c1 != '0));
            check_value("wb1_id_o", int'(wb1_id_o), int'(c1));
            check_value("wb1_rd_o", int'(wb1_rd_o), (c1 != '0) ? int'(m_rd[c1]) : 0);
            e_mask = ref_issue(c0, c1);
            f1 = lowest_free();
            f2 = next_free(f1);
            check_value("issue_o", int'(issue_o), int'(e_mask));
            check_value("inst1_id_o", int'(inst1_id_o), e_mask[0] ? int'(f1) : 0);
            check_value("inst2_id_o", int'(inst2_id_o), e_mask[1] ? int'(f2) : 0);
            check_value("busy_o", int'(busy_o), int'(any_pend));
            // retire, count down, then allocate
            if (c0 != '0) m_pend[c0] = 1'b0;
            if (c1 != '0) m_pend[c1] = 1'b0;
            n_retire += int'(wb0_valid_o) + int'(wb1_valid_o);
            for (int i = 1; i < issue_pkg::NUM_IDS; i++) begin
                if (m_pend[i] && m_rem[i] > 0) m_rem[i]--;
            end
            if (e_mask[0] && inst1_rd_we_i && inst1_rd_i != '0) begin
                m_pend[f1] = 1'b1;
                m_rd[f1]   = inst1_rd_i;
                m_rem[f1]  = op_latency(inst1_op_i) - 1;
                n_alloc++;
            end
            if (e_mask[1] && inst2_rd_we_i && inst2_rd_i != '0) begin
                m_pend[f2] = 1'b1;
                m_rd[f2]   = inst2_rd_i;
                m_rem[f2]  = op_latency(inst2_op_i) - 1;
                n_alloc++;
            end
            n_issue += int'(e_mask[0]) + int'(e_mask[1]);
            if (e_mask == 2'b11) n_dual++;
            last_issue = issue_o;
        end
    end

    task automatic drive_a(
        input logic v, input logic [issue_pkg::REG_ADDR_W-1:0] rs1,
        input logic [issue_pkg::REG_ADDR_W-1:0] rs2, input logic [issue_pkg::REG_ADDR_W-1:0] rd,
        input logic we, input logic [issue_pkg::OP_W-1:0] op, input logic br, input logic jp
    );
        inst1_valid_i  = v;
        inst1_rs1_i    = rs1;
        inst1_rs2_i    = rs2;
        inst1_rd_i     = rd;
        inst1_rd_we_i  = we;
        inst1_op_i     = op;
        inst1_branch_i = br;
        inst1_jump_i   = jp;
    endtask

    task automatic drive_b(
        input logic v, input logic [issue_pkg::REG_ADDR_W-1:0] rs1,
        input logic [issue_pkg::REG_ADDR_W-1:0] rs2, input logic [issue_pkg::REG_ADDR_W-1:0] rd,
        input logic we, input logic [issue_pkg::OP_W-1:0] op
    );
        inst2_valid_i = v;
        inst2_rs1_i   = rs1;
        inst2_rs2_i   = rs2;
        inst2_rd_i    = rd;
        inst2_rd_we_i = we;
        inst2_op_i    = op;
    endtask

    // keep offering stalled slots with irq high for the first irq_cycles
    task automatic hold_pair(input int irq_cycles, input logic rand_irq);
        int waited;
        logic [31:0] r;
        waited = 0;
        while (inst1_valid_i || inst2_valid_i) begin
            @(negedge clk);
            waited++;
            if (last_issue[0]) inst1_valid_i = 1'b0;     // issued so the slot is freed
            if (last_issue[1]) inst2_valid_i = 1'b0;
            if (waited >= irq_cycles) begin
                r = next_rand();
                irq_i = rand_irq && (r[3:0] == 4'd0);
            end
            if (waited > HOLD_LIMIT) begin
                $display("timeout: instruction pair not issued after %0d cycles", waited);
                $display("Test FAILED");
                $fatal(1, "issue stalled");
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        drive_a(1'b0, '0, '0, '0, 1'b0, issue_pkg::OP_ALU, 1'b0, 1'b0);
        drive_b(1'b0, '0, '0, '0, 1'b0, issue_pkg::OP_ALU);
        irq_i = 1'b0;
        while (busy_o) begin
            @(negedge clk);
            waited++;
            if (waited > HOLD_LIMIT) begin
                $display("timeout: scoreboard still busy after %0d cycles", waited);
                $display("Test FAILED");
                $fatal(1, "drain stalled");
            end
        end
    endtask

    // regs x0..x7 only so hazards are common
    task automatic random_pair();
        logic [31:0] r;
        logic [issue_pkg::OP_W-1:0] op;
        r  = next_rand();
        op = (r[15:14] == 2'd3) ? issue_pkg::OP_ALU : r[15:14];
        drive_a(r[2:0] != 3'd0, {2'b00, r[5:3]}, {2'b00, r[8:6]}, {2'b00, r[11:9]},
                r[13:12] != 2'd0, op, r[19:16] == 4'd0, r[23:20] == 4'd0);
        r  = next_rand();
        op = (r[15:14] == 2'd3) ? issue_pkg::OP_ALU : r[15:14];
        drive_b(r[2:0] != 3'd0, {2'b00, r[5:3]}, {2'b00, r[8:6]}, {2'b00, r[11:9]},
                r[13:12] != 2'd0, op);
    endtask

    initial begin
        int start;
        clk       = 1'b0;
        rst_n     = 1'b0;
        irq_i     = 1'b0;
        rng_state = 32'h70c3;
        last_issue = 2'b00;
        n_cycle  = 0;
        n_issue  = 0;
        n_dual   = 0;
        n_alloc  = 0;
        n_retire = 0;
        for (int i = 0; i < issue_pkg::NUM_IDS; i++) begin
            m_pend[i] = 1'b0;
            m_rd[i]   = '0;
            m_rem[i]  = 0;
        end
        drive_a(1'b0, '0, '0, '0, 1'b0, issue_pkg::OP_ALU, 1'b0, 1'b0);
        drive_b(1'b0, '0, '0, '0, 1'b0, issue_pkg::OP_ALU);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // independent pair gives dual issue
        drive_a(1'b1, 5'd1, 5'd2, 5'd3, 1'b1, issue_pkg::OP_ALU, 1'b0, 1'b0);
        drive_b(1'b1, 5'd4, 5'd5, 5'd6, 1'b1, issue_pkg::OP_ALU);
        hold_pair(0, 1'b0);
        drain();
        // mul to x3 and then A reads x3 while B slips past
        drive_a(1'b1, 5'd1, 5'd2, 5'd3, 1'b1, issue_pkg::OP_MUL, 1'b0, 1'b0);
        drive_b(1'b1, 5'd1, 5'd1, 5'd4, 1'b1, issue_pkg::OP_ALU);
        hold_pair(0, 1'b0);
        drive_a(1'b1, 5'd3, 5'd0, 5'd5, 1'b1, issue_pkg::OP_ALU, 1'b0, 1'b0);
        drive_b(1'b1, 5'd7, 5'd7, 5'd6, 1'b1, issue_pkg::OP_ALU);
        hold_pair(0, 1'b0);
        // B reads A's rd and then B overwrites A's rd
        drive_a(1'b1, 5'd0, 5'd0, 5'd1, 1'b1, issue_pkg::OP_ALU, 1'b0, 1'b0);
        drive_b(1'b1, 5'd1, 5'd0, 5'd2, 1'b1, issue_pkg::OP_ALU);
        hold_pair(0, 1'b0);
        drive_a(1'b1, 5'd0, 5'd0, 5'd2, 1'b1, issue_pkg::OP_DIV, 1'b0, 1'b0);
        drive_b(1'b1, 5'd0, 5'd0, 5'd2, 1'b1, issue_pkg::OP_ALU);
        hold_pair(0, 1'b0);
        drain();
        // x0 never conflicts
        drive_a(1'b1, 5'd0, 5'd0, 5'd0, 1'b1, issue_pkg::OP_ALU, 1'b0, 1'b0);
        drive_b(1'b1, 5'd0, 5'd0, 5'd0, 1'b1, issue_pkg::OP_ALU);
        hold_pair(0, 1'b0);
        // branch and then jump in A force single issue
        drive_a(1'b1, 5'd1, 5'd2, 5'd0, 1'b0, issue_pkg::OP_ALU, 1'b1, 1'b0);
        drive_b(1'b1, 5'd3, 5'd4, 5'd5, 1'b1, issue_pkg::OP_ALU);
        hold_pair(0, 1'b0);
        drive_a(1'b1, 5'd0, 5'd0, 5'd1, 1'b1, issue_pkg::OP_ALU, 1'b0, 1'b1);
        drive_b(1'b1, 5'd3, 5'd4, 5'd6, 1'b1, issue_pkg::OP_ALU);
        hold_pair(0, 1'b0);
        // irq stalls both for three cycles
        irq_i = 1'b1;
        drive_a(1'b1, 5'd2, 5'd3, 5'd4, 1'b1, issue_pkg::OP_ALU, 1'b0, 1'b0);
        drive_b(1'b1, 5'd2, 5'd3, 5'd7, 1'b1, issue_pkg::OP_ALU);
        hold_pair(3, 1'b0);
        drain();
        // six divides fill the table so the fourth pair waits for room
        for (int p = 0; p < 3; p++) begin
            drive_a(1'b1, 5'd0, 5'd0, 5'(2 * p + 1), 1'b1, issue_pkg::OP_DIV, 1'b0, 1'b0);
            drive_b(1'b1, 5'd0, 5'd0, 5'(2 * p + 2), 1'b1, issue_pkg::OP_DIV);
            hold_pair(0, 1'b0);
        end
        drive_a(1'b1, 5'd0, 5'd0, 5'd7, 1'b1, issue_pkg::OP_ALU, 1'b0, 1'b0);
        drive_b(1'b1, 5'd0, 5'd0, 5'd0, 1'b0, issue_pkg::OP_ALU);
        hold_pair(0, 1'b0);
        drain();
        // div pair and mul pair become eligible together
        drive_a(1'b1, 5'd0, 5'd0, 5'd1, 1'b1, issue_pkg::OP_DIV, 1'b0, 1'b0);
        drive_b(1'b1, 5'd0, 5'd0, 5'd2, 1'b1, issue_pkg::OP_DIV);
        hold_pair(0, 1'b0);
        repeat (2) @(negedge clk);
        drive_a(1'b1, 5'd0, 5'd0, 5'd3, 1'b1, issue_pkg::OP_MUL, 1'b0, 1'b0);
        drive_b(1'b1, 5'd0, 5'd0, 5'd4, 1'b1, issue_pkg::OP_MUL);
        hold_pair(0, 1'b0);
        drain();
        $display("directed phase done at cycle %0d", n_cycle);

        start = n_cycle;
        while (n_cycle - start < RAND_CYCLES) begin
            random_pair();
            hold_pair(0, 1'b1);
        end
        drain();

        if (n_retire != n_alloc) begin
            $display("retired %0d writes but allocated %0d", n_retire, n_alloc);
            $display("Test FAILED");
            $fatal(1, "retirement count");
        end else begin
            $display("cycles %0d issued %0d dual %0d retired %0d",
                     n_cycle, n_issue, n_dual, n_retire);
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
